//--- Makefile
# Verilator build and run of the bus interface controller testbench
VERILATOR ?= verilator
TOP       ?= ifbus_tb
FILELIST  ?= ifbus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- if_alarm_timer.sv
`timescale 1ns/1ps

// no-answer alarm for the bus interface
// the first counter stands in for the old delay line and the second one
// for the one-shot that stretched the alarm to a fixed length
module if_alarm_timer #(
	parameter int unsigned ALARM_DLY_TICKS = 12,
	parameter int unsigned ALARM_TICKS     = 4
) (
	input  logic ok_clk,
	input  logic zgi,
	input  logic bus_drv,
	input  logic rok,
	input  logic ren,
	output logic talarm
);

	localparam int unsigned DLY_W = $clog2(ALARM_DLY_TICKS + 1);
	localparam int unsigned PLS_W = $clog2(ALARM_TICKS + 1);
	localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(ALARM_DLY_TICKS - 1);
	localparam logic [PLS_W-1:0] PLS_LEN  = PLS_W'(ALARM_TICKS);

	logic [DLY_W-1:0] dly_cnt;
	logic [PLS_W-1:0] pls_cnt;
	logic             fired;
	logic             waiting;
	logic             expire;

	// granted bus with no answer on either line
	assign waiting = bus_drv & ~(rok | ren);

	// the last waiting cycle of the delay, taken only once per phase
	assign expire = waiting & ~fired & (dly_cnt == DLY_LAST);

	always_ff @(posedge ok_clk or negedge zgi) begin
		if (!zgi) begin
			dly_cnt <= '0;
			fired   <= 1'b0;
			pls_cnt <= '0;
		end else begin
			// any break in the waiting phase starts the delay over
			if (!waiting) begin
				dly_cnt <= '0;
				fired   <= 1'b0;
			end else if (expire) begin
				fired <= 1'b1;
			end else if (!fired) begin
				dly_cnt <= dly_cnt + 1'b1;
			end
			// the pulse runs down on its own once loaded
			// so it keeps its length even after zg has gone
			if (expire)
				pls_cnt <= PLS_LEN;
			else if (pls_cnt != '0)
				pls_cnt <= pls_cnt - 1'b1;
		end
	end

	assign talarm = (pls_cnt != '0);

endmodule

//--- if_data_path.sv
`timescale 1ns/1ps

// address and data side of the bus interface
// the request is latched when the controller takes a start
// and it stays stable on the bus for the whole access
module if_data_path #(
	parameter int unsigned ADDR_W = 16,
	parameter int unsigned DATA_W = 16
) (
	input  logic                ok_clk,
	input  logic                zgi,
	input  logic                start,
	input  logic                busy,
	input  ifbus_pkg::bus_op_t  op,
	input  logic [ADDR_W-1:0]   addr,
	input  logic [DATA_W-1:0]   wdata,
	input  logic                bus_drv,
	input  logic                capture,
	input  logic [DATA_W-1:0]   bus_rdata,
	output logic [ADDR_W-1:0]   bus_addr,
	output logic [DATA_W-1:0]   bus_wdata,
	output logic [DATA_W-1:0]   rdata
);
	import ifbus_pkg::*;

	bus_op_t           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic              accept;
	logic              drive_wdata;

	// the same condition the state machine uses to take a start
	assign accept = start & ~busy;

	// the operation decides what goes on the data lines
	always_ff @(posedge ok_clk or negedge zgi) begin
		if (!zgi)
			op_q <= op_read;
		else if (accept)
			op_q <= op;
	end

	always_ff @(posedge ok_clk) begin
		if (accept) begin
			addr_q  <= addr;
			wdata_q <= wdata;
		end
	end

	// read data is taken on the edge that accepts the answer
	// a negative answer also raises capture but a write never loads rdata
	always_ff @(posedge ok_clk) begin
		if (capture && op_q == op_read)
			rdata <= bus_rdata;
	end

	// the address simply follows the latched request
	assign bus_addr = addr_q;

	// write data is only put out while we own the bus for a write
	// otherwise the lines read as zero
	assign drive_wdata = bus_drv & (op_q == op_write);
	assign bus_wdata   = drive_wdata ? wdata_q : '0;

endmodule

//--- if_request_fsm.sv
`timescale 1ns/1ps

// control of the bus request for one processor
// the request zg is the OR of three terms as in the old flip-flop design
// the first term is the request itself, the second the atomic hold and the third the answer
// that still persists after the access is over
module if_request_fsm (
	input  logic                  ok_clk,
	input  logic                  zgi,
	input  logic                  start,
	input  logic                  hold,
	input  logic                  zw,
	input  logic                  rok,
	input  logic                  ren,
	input  logic                  talarm,
	output logic                  zg,
	output logic                  busy,
	output logic                  bus_drv,
	output logic                  done,
	output ifbus_pkg::if_result_t result,
	output logic                  capture
);
	import ifbus_pkg::*;

	// idle and held are the two states where a new start is taken
	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_REQUEST = 3'd1;
	localparam logic [2:0] S_WAIT    = 3'd2;
	localparam logic [2:0] S_FINISH  = 3'd3;
	localparam logic [2:0] S_RELEASE = 3'd4;
	localparam logic [2:0] S_HELD    = 3'd5;

	logic [2:0] state;
	logic [2:0] state_nxt;
	logic       hold_q;
	logic       armed;
	logic       talarm_q;
	logic       alarm_rise;
	logic       oken;
	logic       accept;
	logic       req_on;
	logic       hold_on;
	logic       ans_persist;

	assign oken   = rok | ren;
	assign accept = start & ~busy;

	// the pulse may still be running from the previous transaction
	// so only its rising edge ends an access
	assign alarm_rise = talarm & ~talarm_q;

	// the three terms of the request
	assign req_on      = (state == S_WAIT) | (state == S_FINISH);
	assign hold_on     = (state == S_HELD);
	assign ans_persist = (state == S_RELEASE);
	assign zg          = req_on | hold_on | ans_persist;

	// the request state already counts as busy so a second start cannot slip in
	// before zg is up
	assign busy    = state inside {S_REQUEST, S_WAIT, S_FINISH, S_RELEASE};
	assign bus_drv = zg & zw;
	assign done    = (state == S_FINISH);

	// an answer is only taken when it is fresh
	// after an atomic first half the device must first drop its old answer
	assign capture = (state == S_WAIT) & zw & oken & armed & ~alarm_rise;

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (accept)
					state_nxt = S_REQUEST;
			end
			// one cycle for the latched request to settle before zg goes out
			S_REQUEST: state_nxt = S_WAIT;
			S_WAIT: begin
				if (alarm_rise | capture)
					state_nxt = S_FINISH;
			end
			S_FINISH: begin
				// an alarm drops the bus at once, whatever the hold flag says
				if (result == res_alarm)
					state_nxt = S_IDLE;
				else if (hold_q)
					state_nxt = S_HELD;
				else if (oken)
					state_nxt = S_RELEASE;
				else
					state_nxt = S_IDLE;
			end
			// zg stays up until the device has let go of its answer line
			S_RELEASE: begin
				if (!oken)
					state_nxt = S_IDLE;
			end
			S_HELD: begin
				// the bus is still granted so the second half skips the request cycle
				// an alarm during the same edge ends that second half straight away
				if (accept & alarm_rise)
					state_nxt = S_FINISH;
				else if (accept)
					state_nxt = S_WAIT;
				else if (alarm_rise)
					state_nxt = S_IDLE;
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge ok_clk or negedge zgi) begin
		if (!zgi) begin
			state    <= S_IDLE;
			hold_q   <= 1'b0;
			armed    <= 1'b1;
			talarm_q <= 1'b0;
			result   <= res_ok;
		end else begin
			state    <= state_nxt;
			talarm_q <= talarm;
			// every accepted access sets or clears the hold, so a plain one ends it
			if (accept)
				hold_q <= hold;
			// the device showed a low answer line, so its next answer is a new one
			if (capture)
				armed <= 1'b0;
			else if (!oken)
				armed <= 1'b1;
			if ((state == S_WAIT || (state == S_HELD && accept)) && alarm_rise)
				result <= res_alarm;
			else if (capture)
				result <= rok ? res_ok : res_en;
		end
	end

endmodule

//--- ifbus.f
ifbus_pkg.sv
if_request_fsm.sv
if_alarm_timer.sv
if_data_path.sv
ifbus_top.sv
ifbus_props.sv
ifbus_tb.sv

//--- ifbus_pkg.sv
// shared types for the bus interface controller and its testbench
package ifbus_pkg;

	// the access the sequencer asks for
	// the encoding is one bit so it can travel next to the address
	typedef enum logic [0:0] {
		op_read  = 1'b0,
		op_write = 1'b1
	} bus_op_t;

	// how a bus transaction ended
	// res_ok is a positive answer (rok) from the addressed device
	// res_en is a negative answer (ren), the device refused the access
	// res_alarm means nobody answered before the no-answer timer ran out
	typedef enum logic [1:0] {
		res_ok    = 2'd0,
		res_en    = 2'd1,
		res_alarm = 2'd2
	} if_result_t;

	// the value 2'd3 is never produced by the controller
	// a sequencer that sees it on result is looking at a broken design

endpackage

//--- ifbus_props.sv
`timescale 1ns/1ps

// handshake rules of the system bus, checked on the controller top level
module ifbus_props (
	input logic ok_clk,
	input logic zgi,
	input logic zg,
	input logic zw,
	input logic rok,
	input logic ren,
	input logic done,
	input logic bus_drv,
	input logic talarm
);

	// number of failed properties so far
	int fail_cnt = 0;

	// done is a strobe and never a level
	done_one_cycle: assert property (@(posedge ok_clk) disable iff (!zgi) done |=> !done)
		else begin
			fail_cnt++;
			$error("done stayed high for more than one cycle");
		end

	// the data lines are only driven while we own the granted bus
	drive_needs_grant: assert property (@(posedge ok_clk) disable iff (!zgi)
		bus_drv |-> zg && zw)
		else begin
			fail_cnt++;
			$error("bus_drv high without zg and zw");
		end

	// an answer keeps the request up, only the alarm may cut it short
	answer_keeps_zg: assert property (@(posedge ok_clk) disable iff (!zgi)
		zg && (rok || ren) && !talarm |=> zg)
		else begin
			fail_cnt++;
			$error("zg dropped while the answer line was still high");
		end

	// the alarm only starts on a requested bus
	alarm_needs_zg: assert property (@(posedge ok_clk) disable iff (!zgi)
		$rose(talarm) |-> zg)
		else begin
			fail_cnt++;
			$error("talarm rose while zg was low");
		end

endmodule

bind ifbus_top ifbus_props u_props (
	.ok_clk  (ok_clk),
	.zgi     (zgi),
	.zg      (zg),
	.zw      (zw),
	.rok     (rok),
	.ren     (ren),
	.done    (done),
	.bus_drv (bus_drv),
	.talarm  (talarm)
);

//--- ifbus_tb.sv
`timescale 1ns/1ps

// directed testbench for the bus interface controller
// a small device model grants the bus and answers from a 16 word memory
module ifbus_tb;
	import ifbus_pkg::*;

	localparam int ADDR_W          = 16;
	localparam int DATA_W          = 16;
	localparam int ALARM_DLY_TICKS = 12;
	localparam int ALARM_TICKS     = 4;
	localparam int ANS_OK          = 0;
	localparam int ANS_REN         = 1;
	localparam int ANS_NONE        = 2;

	logic              ok_clk    = 1'b0;
	logic              zgi       = 1'b0;
	logic              start     = 1'b0;
	bus_op_t           op        = op_read;
	logic [ADDR_W-1:0] addr      = '0;
	logic [DATA_W-1:0] wdata     = '0;
	logic              hold      = 1'b0;
	logic              zw        = 1'b0;
	logic              rok       = 1'b0;
	logic              ren       = 1'b0;
	logic [DATA_W-1:0] bus_rdata = '0;
	logic              busy;
	logic              done;
	logic              zg;
	logic              bus_drv;
	logic              talarm;
	if_result_t        result;
	logic [DATA_W-1:0] rdata;
	logic [ADDR_W-1:0] bus_addr;
	logic [DATA_W-1:0] bus_wdata;

	// device model, its memory and how it behaves on the next access
	logic [DATA_W-1:0] mem [16];
	bus_op_t           cur_op    = op_read;
	int                grant_dly = 0;
	int                ans_dly   = 1;
	int                ans_len   = 3;
	int                ans_mode  = ANS_OK;
	int                gcnt      = 0;
	int                acnt      = 0;
	int                hcnt      = 0;
	logic              answered  = 1'b0;

	// what the last access returned
	if_result_t        got_result;
	logic [DATA_W-1:0] got_rdata;
	logic              alarm_seen = 1'b0;
	integer            seed;
	logic [31:0]       rnd;

	ifbus_top #(
		.ADDR_W          (ADDR_W),
		.DATA_W          (DATA_W),
		.ALARM_DLY_TICKS (ALARM_DLY_TICKS),
		.ALARM_TICKS     (ALARM_TICKS)
	) DUT (.*);

	always #10 ok_clk = ~ok_clk;

	// the device grants after grant_dly cycles and answers ans_dly cycles later
	// it lets go of the answer after ans_len cycles, or at once when zg falls
	always @(posedge ok_clk) begin
		if (!zg) begin
			zw       <= 1'b0;
			rok      <= 1'b0;
			ren      <= 1'b0;
			gcnt     <= 0;
			acnt     <= 0;
			hcnt     <= 0;
			answered <= 1'b0;
		end else begin
			if (!zw && gcnt >= grant_dly)
				zw <= 1'b1;
			else if (!zw)
				gcnt <= gcnt + 1;
			// a held bus with the controller idle means the next access is a new one
			if (!busy)
				answered <= 1'b0;
			if (rok || ren) begin
				hcnt <= hcnt + 1;
				if (hcnt >= ans_len - 1) begin
					rok  <= 1'b0;
					ren  <= 1'b0;
					hcnt <= 0;
				end
			end else if (zw && busy && !answered && ans_mode != ANS_NONE) begin
				acnt <= acnt + 1;
				if (acnt >= ans_dly) begin
					acnt     <= 0;
					answered <= 1'b1;
					if (ans_mode == ANS_REN)
						ren <= 1'b1;
					else
						rok <= 1'b1;
					if (ans_mode == ANS_OK && cur_op == op_write)
						mem[bus_addr[3:0]] <= bus_wdata;
					else if (ans_mode == ANS_OK)
						bus_rdata <= mem[bus_addr[3:0]];
				end
			end
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR time=%0t signal=%s got=%0h expected=%0h",
				$time, name, got, exp));
	endtask

	task automatic wait_not_busy();
		int n;
		for (n = 0; n < 200 && busy; n++)
			@(negedge ok_clk);
		if (busy)
			abort_run("timeout: the controller stayed busy");
	endtask

	// waits for zg, zw and both answer lines to go low
	// while an answer is up the request must stay up as well
	task automatic wait_bus_idle();
		int n;
		for (n = 0; n < 100 && (zg || zw || rok || ren); n++) begin
			@(negedge ok_clk);
			if (rok || ren)
				check("zg", 32'(zg), 32'd1);
		end
		if (zg || zw || rok || ren)
			abort_run("timeout: the bus did not go back to idle");
	endtask

	task automatic issue_start(input bus_op_t o, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, input logic h);
		@(posedge ok_clk);
		start  <= 1'b1;
		op     <= o;
		addr   <= a;
		wdata  <= d;
		hold   <= h;
		cur_op <= o;
		@(posedge ok_clk);
		start <= 1'b0;
	endtask

	// bus lines are checked in every granted cycle until done comes
	task automatic wait_done(input logic [ADDR_W-1:0] exp_addr,
		input logic [DATA_W-1:0] exp_wdata);
		int   n;
		logic got;
		got = 1'b0;
		for (n = 0; n < 100 && !got; n++) begin
			@(negedge ok_clk);
			if (talarm)
				alarm_seen = 1'b1;
			if (bus_drv) begin
				check("bus_addr", 32'(bus_addr), 32'(exp_addr));
				check("bus_wdata", 32'(bus_wdata),
					cur_op == op_write ? 32'(exp_wdata) : 32'd0);
			end
			if (done) begin
				got        = 1'b1;
				got_result = result;
				got_rdata  = rdata;
			end
		end
		if (!got)
			abort_run("timeout: done never came for the access");
	endtask

	task automatic do_access(input bus_op_t o, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, input logic h);
		wait_not_busy();
		issue_start(o, a, d, h);
		wait_done(a, d);
	endtask

	task automatic test_write_read();
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		grant_dly = 2;
		ans_mode  = ANS_OK;
		rnd       = $random(seed);
		a         = rnd[15:0];
		d         = rnd[31:16];
		do_access(op_write, a, d, 1'b0);
		check("result", 32'(got_result), 32'(res_ok));
		wait_bus_idle();
		do_access(op_read, a, '0, 1'b0);
		check("result", 32'(got_result), 32'(res_ok));
		check("rdata", 32'(got_rdata), 32'(d));
		wait_bus_idle();
	endtask

	task automatic test_negative_answer();
		grant_dly = 0;
		ans_mode  = ANS_REN;
		ans_len   = 4;
		rnd       = $random(seed);
		do_access(op_read, rnd[15:0], '0, 1'b0);
		check("result", 32'(got_result), 32'(res_en));
		check("zg", 32'(zg), 32'd1);
		wait_bus_idle();
	endtask

	task automatic test_no_answer();
		int   n;
		int   pulse;
		logic got;
		grant_dly = 1;
		ans_mode  = ANS_NONE;
		pulse     = 0;
		got       = 1'b0;
		wait_not_busy();
		issue_start(op_read, 16'h0040, '0, 1'b0);
		for (n = 0; n < 100 && !talarm; n++) begin
			@(negedge ok_clk);
			if (done)
				abort_run("done came before the no-answer alarm");
		end
		if (!talarm)
			abort_run("timeout: the no-answer alarm never came");
		for (n = 0; n < 20 && talarm; n++) begin
			pulse++;
			if (done) begin
				got        = 1'b1;
				got_result = result;
			end
			@(negedge ok_clk);
		end
		check("talarm cycles", 32'(pulse), 32'(ALARM_TICKS));
		check("done", 32'(got), 32'd1);
		check("result", 32'(got_result), 32'(res_alarm));
		check("zg", 32'(zg), 32'd0);
		wait_bus_idle();
	endtask

	// read with hold, then the write half on the still granted bus
	task automatic test_atomic_pair();
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] old;
		grant_dly = 1;
		ans_mode  = ANS_OK;
		ans_len   = 2;
		rnd       = $random(seed);
		a         = rnd[15:0];
		old       = mem[a[3:0]];
		do_access(op_read, a, '0, 1'b1);
		check("result", 32'(got_result), 32'(res_ok));
		check("rdata", 32'(got_rdata), 32'(old));
		repeat (2) begin
			@(negedge ok_clk);
			check("zg", 32'(zg), 32'd1);
		end
		do_access(op_write, a, old + 16'd1, 1'b0);
		check("result", 32'(got_result), 32'(res_ok));
		wait_bus_idle();
		check("mem", 32'(mem[a[3:0]]), 32'(old + 16'd1));
	endtask

	task automatic test_busy_and_late_grant();
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		logic [DATA_W-1:0] other;
		grant_dly  = 30;
		ans_len    = 3;
		alarm_seen = 1'b0;
		rnd        = $random(seed);
		a          = rnd[15:0];
		d          = rnd[31:16];
		other      = mem[a[3:0] ^ 4'h1];
		wait_not_busy();
		issue_start(op_write, a, d, 1'b0);
		// the second start lands while busy is high
		issue_start(op_write, a ^ 16'h0001, ~d, 1'b0);
		wait_done(a, d);
		check("result", 32'(got_result), 32'(res_ok));
		wait_bus_idle();
		check("mem", 32'(mem[a[3:0]]), 32'(d));
		check("mem", 32'(mem[a[3:0] ^ 4'h1]), 32'(other));
		check("talarm seen", 32'(alarm_seen), 32'd0);
	endtask

	initial begin
		seed = 32'h583c1e48;
		for (int i = 0; i < 16; i++)
			mem[i] <= 16'hc35a ^ (16'(i) * 16'h1111);
		repeat (2) @(posedge ok_clk);
		check("zg", 32'(zg), 32'd0);
		check("busy", 32'(busy), 32'd0);
		check("done", 32'(done), 32'd0);
		check("bus_drv", 32'(bus_drv), 32'd0);
		check("talarm", 32'(talarm), 32'd0);
		zgi <= 1'b1;
		@(negedge ok_clk);
		test_write_read();
		test_negative_answer();
		test_no_answer();
		test_atomic_pair();
		test_busy_and_late_grant();
		if (DUT.u_props.fail_cnt != 0)
			abort_run("a handshake assertion failed during the run");
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

//--- ifbus_top.sv
`timescale 1ns/1ps

// bus interface controller between the instruction sequencer and the system bus
// it only connects the request FSM, the alarm timer and the data path
module ifbus_top #(
	parameter int unsigned ADDR_W          = 16,
	parameter int unsigned DATA_W          = 16,
	parameter int unsigned ALARM_DLY_TICKS = 12,
	parameter int unsigned ALARM_TICKS     = 4
) (
	input  logic                  ok_clk,
	input  logic                  zgi,
	// sequencer side
	input  logic                  start,
	input  ifbus_pkg::bus_op_t    op,
	input  logic [ADDR_W-1:0]     addr,
	input  logic [DATA_W-1:0]     wdata,
	input  logic                  hold,
	output logic                  busy,
	output logic                  done,
	output ifbus_pkg::if_result_t result,
	output logic [DATA_W-1:0]     rdata,
	// system bus side
	output logic                  zg,
	input  logic                  zw,
	input  logic                  rok,
	input  logic                  ren,
	output logic                  bus_drv,
	output logic [ADDR_W-1:0]     bus_addr,
	output logic [DATA_W-1:0]     bus_wdata,
	input  logic [DATA_W-1:0]     bus_rdata,
	output logic                  talarm
);

	// tells the data path on which edge the answer is taken
	logic capture;

	if_request_fsm u_fsm (
		.ok_clk  (ok_clk),
		.zgi     (zgi),
		.start   (start),
		.hold    (hold),
		.zw      (zw),
		.rok     (rok),
		.ren     (ren),
		.talarm  (talarm),
		.zg      (zg),
		.busy    (busy),
		.bus_drv (bus_drv),
		.done    (done),
		.result  (result),
		.capture (capture)
	);

	if_alarm_timer #(
		.ALARM_DLY_TICKS (ALARM_DLY_TICKS),
		.ALARM_TICKS     (ALARM_TICKS)
	) u_alarm (
		.ok_clk  (ok_clk),
		.zgi     (zgi),
		.bus_drv (bus_drv),
		.rok     (rok),
		.ren     (ren),
		.talarm  (talarm)
	);

	if_data_path #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W)
	) u_data (
		.ok_clk    (ok_clk),
		.zgi       (zgi),
		.start     (start),
		.busy      (busy),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.bus_drv   (bus_drv),
		.capture   (capture),
		.bus_rdata (bus_rdata),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.rdata     (rdata)
	);

endmodule
